// ==== verilog/mod_pkg.sv ====
package mod_pkg;

  // residue width and the modulus itself
  localparam int unsigned RESIDUE_W = 12;
  localparam logic [RESIDUE_W-1:0] MODULUS = 12'd4051;

  // operand is sliced into small digits for the lookup tables
  localparam int unsigned OPERAND_W = 200;
  localparam int unsigned DIGIT_W = 6;
  localparam int unsigned NUM_DIGITS = (OPERAND_W + DIGIT_W - 1) / DIGIT_W;

  // digit 33 only carries the two top operand bits
  localparam int unsigned TOP_DIGIT_W = OPERAND_W - (NUM_DIGITS - 1) * DIGIT_W;

  // first tree level adds residues three at a time
  localparam int unsigned GROUP_SIZE = 3;
  localparam int unsigned NUM_GROUPS = (NUM_DIGITS + GROUP_SIZE - 1) / GROUP_SIZE;

  // 3 * 4050 = 12150 needs 14 bits
  localparam int unsigned PART_W = 14;

  // 34 * 4050 = 137700 needs 18 bits
  localparam int unsigned SUM_W = 18;

  // 2^12 mod 4051, used to fold the bits above the residue width
  localparam logic [RESIDUE_W-1:0] FOLD_K = 12'd45;

  // folded value stays below 2 * MODULUS so one extra bit is enough
  localparam int unsigned FOLD_W = RESIDUE_W + 1;

  // weight of digit position idx, i.e. 2^(DIGIT_W * idx) mod MODULUS
  // doubling one bit at a time keeps the running value below MODULUS
  function automatic logic [RESIDUE_W-1:0] digit_weight(input int unsigned idx);
    int unsigned w;
    w = 1;
    for (int unsigned i = 0; i < DIGIT_W * idx; i++)
    begin
      w = w << 1;
      // subtract once, w was below MODULUS before the shift
      if (w >= MODULUS)
      begin
        w = w - MODULUS;
      end
    end
    return RESIDUE_W'(w);
  endfunction

endpackage

// ==== verilog/digit_residue_rom.sv ====
`timescale 1ns/1ps

// one digit of the operand mapped to its weighted residue
// res = (digit * 2^(6 * IDX)) mod 4051
module digit_residue_rom #(
  parameter int unsigned IDX = 0,
  parameter int unsigned DIGIT_BITS = mod_pkg::DIGIT_W
) (
  input  logic [DIGIT_BITS-1:0]         digit,
  output logic [mod_pkg::RESIDUE_W-1:0] res
);

  import mod_pkg::*;

  // table contents are pure constants, one entry per digit value
  logic [RESIDUE_W-1:0] rom [2**DIGIT_BITS];

  // fill the table at elaboration
  // entry e holds e times the position weight, reduced mod MODULUS
  // max product 63 * 4050 fits easily in 32 bits
  generate
    for (genvar e = 0; e < 2**DIGIT_BITS; e++)
    begin : gen_entry
      assign rom[e] = RESIDUE_W'((e * digit_weight(IDX)) % MODULUS);
    end
  endgenerate

  // plain lookup, purely combinational
  assign res = rom[digit];

endmodule

// ==== verilog/residue_adder_tree.sv ====
`timescale 1ns/1ps

// two-stage registered adder tree
// stage 1 sums the 34 digit residues in groups of three
// stage 2 sums the 12 partial sums into one 18-bit value
module residue_adder_tree (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  in_valid,
  input  logic [mod_pkg::NUM_DIGITS-1:0][mod_pkg::RESIDUE_W-1:0] digit_res,
  output logic                                                  sum_valid,
  output logic [mod_pkg::SUM_W-1:0]                             sum
);

  import mod_pkg::*;

  // stage 1 partial sums before and after the register
  logic [NUM_GROUPS-1:0][PART_W-1:0] part_d;
  logic [NUM_GROUPS-1:0][PART_W-1:0] part_q;
  logic                              part_valid;

  // stage 2 combined sum before the register
  logic [SUM_W-1:0]                  sum_d;

  // stage 1 adder groups
  // group g covers residues 3g, 3g+1 and 3g+2
  // last group only has digit 33 since 34 is not a multiple of three
  always_comb
  begin
    for (int g = 0; g < NUM_GROUPS; g++)
    begin
      part_d[g] = '0;
      for (int m = 0; m < GROUP_SIZE; m++)
      begin
        // skip slots past the last digit
        if (g * GROUP_SIZE + m < NUM_DIGITS)
        begin
          part_d[g] = part_d[g] + PART_W'(digit_res[g * GROUP_SIZE + m]);
        end
      end
    end
  end

  // stage 1 valid follows in_valid one cycle later
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      part_valid <= 1'b0;
    end
    else
    begin
      part_valid <= in_valid;
    end
  end

  // partial sums only load when an operand is present
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      part_q <= part_d;
    end
  end

  // stage 2 adds all twelve partial sums
  // worst case 34 * 4050 = 137700 still fits in SUM_W bits
  always_comb
  begin
    sum_d = '0;
    for (int g = 0; g < NUM_GROUPS; g++)
    begin
      sum_d = sum_d + SUM_W'(part_q[g]);
    end
  end

  // stage 2 valid, cleared on reset so in-flight operands vanish
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sum_valid <= 1'b0;
    end
    else
    begin
      sum_valid <= part_valid;
    end
  end

  // final sum register
  always_ff @(posedge clk)
  begin
    if (part_valid)
    begin
      sum <= sum_d;
    end
  end

  // total latency in_valid -> sum_valid is two cycles
  // throughput is one operand per cycle, no stall path

endmodule

// ==== verilog/fold_reduce.sv ====
`timescale 1ns/1ps

// last pipeline stage
// folds the 18-bit sum with 2^12 = 45 (mod 4051)
// then one conditional subtraction gives the final residue
module fold_reduce (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sum_valid,
  input  logic [mod_pkg::SUM_W-1:0]     sum,
  output logic                          out_valid,
  output logic [mod_pkg::RESIDUE_W-1:0] residue
);

  import mod_pkg::*;

  // low part is the bits below 2^12
  logic [RESIDUE_W-1:0]         sum_lo;
  // high part is weighted by 2^12, replaced by FOLD_K
  logic [SUM_W-RESIDUE_W-1:0]   sum_hi;
  // folded value and its correction
  logic [FOLD_W-1:0]            fold_sum;
  logic [FOLD_W-1:0]            fold_sub;
  logic [RESIDUE_W-1:0]         residue_d;

  assign sum_lo = sum[RESIDUE_W-1:0];
  assign sum_hi = sum[SUM_W-1:RESIDUE_W];

  // worst case 4095 + 45 * 63 = 6930
  // always below 2 * 4051 = 8102, so one subtraction is enough
  assign fold_sum = FOLD_W'(sum_lo) + FOLD_W'(FOLD_K) * FOLD_W'(sum_hi);

  // value minus the modulus, only used when it does not wrap
  assign fold_sub = fold_sum - FOLD_W'(MODULUS);

  // conditional subtract of the modulus
  always_comb
  begin
    if (fold_sum >= FOLD_W'(MODULUS))
    begin
      residue_d = fold_sub[RESIDUE_W-1:0];
    end
    else
    begin
      residue_d = fold_sum[RESIDUE_W-1:0];
    end
  end

  // output valid, one cycle after sum_valid
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= sum_valid;
    end
  end

  // residue register, holds the last result when idle
  always_ff @(posedge clk)
  begin
    if (sum_valid)
    begin
      residue <= residue_d;
    end
  end

endmodule

// ==== verilog/mod_reduce_top.sv ====
`timescale 1ns/1ps

// 200-bit operand mod 4051, fully pipelined
// fixed latency of three cycles from in_valid to out_valid
// new operand accepted every cycle, no back-pressure
module mod_reduce_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  input  logic [mod_pkg::OPERAND_W-1:0] operand,
  output logic                          out_valid,
  output logic [mod_pkg::RESIDUE_W-1:0] residue
);

  import mod_pkg::*;

  // one weighted residue per digit position
  logic [NUM_DIGITS-1:0][RESIDUE_W-1:0] digit_res;

  // adder tree to fold stage
  logic                                 sum_valid;
  logic [SUM_W-1:0]                     sum;

  // digit tables
  // digit k covers operand bits 6k+5 down to 6k
  // the last one only sees the two top bits
  generate
    for (genvar k = 0; k < NUM_DIGITS; k++)
    begin : gen_digit
      if (k < NUM_DIGITS - 1)
      begin : gen_full
        digit_residue_rom #(
          .IDX        (k),
          .DIGIT_BITS (DIGIT_W)
        ) rom_i (
          .digit (operand[k * DIGIT_W +: DIGIT_W]),
          .res   (digit_res[k])
        );
      end
      else
      begin : gen_top
        digit_residue_rom #(
          .IDX        (k),
          .DIGIT_BITS (TOP_DIGIT_W)
        ) rom_i (
          .digit (operand[OPERAND_W-1 -: TOP_DIGIT_W]),
          .res   (digit_res[k])
        );
      end
    end
  endgenerate

  // two register stages of residue summation
  residue_adder_tree tree_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .digit_res (digit_res),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  // fold plus final subtract, third register stage
  fold_reduce fold_i (
    .clk       (clk),
    .reset     (reset),
    .sum_valid (sum_valid),
    .sum       (sum),
    .out_valid (out_valid),
    .residue   (residue)
  );

endmodule

// ==== dv/mod_reduce_model.svh ====
`ifndef MOD_REDUCE_MODEL_SVH
`define MOD_REDUCE_MODEL_SVH

// reference model for a 200-bit operand modulo 4051
// long division one bit at a time starting from the top bit
function automatic logic [11:0] expected_residue(input logic [199:0] op);
  int unsigned rem;
  rem = 0;
  for (int i = 199; i >= 0; i--)
  begin
    // remainder is below 4051 before the shift
    // so after the shift it is below 8102
    rem = (rem << 1) | op[i];
    // one subtraction brings it back under the divisor
    if (rem >= 4051)
    begin
      rem = rem - 4051;
    end
  end
  return 12'(rem);
endfunction

`endif

// ==== dv/mod_reduce_tb.sv ====
`timescale 1ns/1ps

// testbench for the pipelined 200-bit mod 4051 unit
module mod_reduce_tb;

  import mod_pkg::*;

  `include "mod_reduce_model.svh"

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CHECK_CYCLES = 10;
  localparam int DRAIN_LIMIT = 20;

  // in_valid sampled at edge N is stamped with that edge
  // out_valid is registered at edge N+2 and seen by the scoreboard at N+3
  localparam int LATENCY = 3;

  // operand counts of the individual tests
  localparam int N_CORNER = 5 + OPERAND_W + 1;
  localparam int N_DIGIT = 2 * NUM_DIGITS;
  localparam int N_BURST = 500;
  localparam int N_GAPPED = 300;
  localparam int N_RST_PRE = 12;
  localparam int N_RST_POST = 20;
  localparam int TOTAL_OPS = N_CORNER + N_DIGIT + N_BURST + N_GAPPED + N_RST_PRE + N_RST_POST;

  // gapped stream idles about half of its cycles
  // two cycles per operand plus margin for reset, drains and idle checks
  localparam int WATCHDOG_CYCLES = 2 * TOTAL_OPS + 200;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 in_valid;
  logic [OPERAND_W-1:0] operand;
  logic                 out_valid;
  logic [RESIDUE_W-1:0] residue;

  int seed = 32'h6027;

  // global and per-test counters
  int n_checks = 0;
  int n_errors = 0;
  int test_checks;
  int test_errors;

  // expected residues and the edge at which each operand was taken
  logic [RESIDUE_W-1:0] exp_q[$];
  int                   stamp_q[$];
  int                   cycle = 0;

  mod_reduce_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .operand   (operand),
    .out_valid (out_valid),
    .residue   (residue)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED at time %0t: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  // scoreboard
  // compare first so a result leaving on a reset edge is still checked
  always @(posedge clk)
  begin : scoreboard
    logic [RESIDUE_W-1:0] want;
    int                   taken_at;
    if (out_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        n_errors++;
        $display("ERROR at time %0t: out_valid high with no operand outstanding", $time);
      end
      else
      begin
        want = exp_q.pop_front();
        taken_at = stamp_q.pop_front();
        check_value("residue", residue, want);
        check_value("edges from in_valid to out_valid", cycle - taken_at, LATENCY);
      end
    end
    // reset drops everything still in flight
    if (reset === 1'b1)
    begin
      exp_q.delete();
      stamp_q.delete();
    end
    else if (in_valid === 1'b1)
    begin
      exp_q.push_back(expected_residue(operand));
      stamp_q.push_back(cycle);
    end
    cycle++;
  end

  task automatic send_operand(input logic [OPERAND_W-1:0] op);
    operand <= op;
    in_valid <= 1'b1;
    @(posedge clk);
  endtask

  task automatic idle_cycle();
    in_valid <= 1'b0;
    @(posedge clk);
  endtask

  // seven 32-bit words cut down to the operand width
  task automatic random_operand(output logic [OPERAND_W-1:0] op);
    logic [7*32-1:0] wide;
    logic [31:0]     word;
    wide = '0;
    for (int i = 0; i < 7; i++)
    begin
      word = $random(seed);
      wide = {wide[6*32-1:0], word};
    end
    op = wide[OPERAND_W-1:0];
  endtask

  task automatic start_test();
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  // wait for outstanding results, sampled on the falling edge
  task automatic end_test(input string name);
    int waited;
    in_valid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      n_errors++;
      $display("ERROR: %0d results never arrived in test %s", exp_q.size(), name);
      exp_q.delete();
      stamp_q.delete();
    end
    $display("test %-20s %0d checks, %0d errors", name, n_checks - test_checks,
             n_errors - test_errors);
    @(posedge clk);
  endtask

  initial
  begin : main
    logic [OPERAND_W-1:0] op;
    logic [31:0]          r;
    int                   n;
    reset = 1'b1;
    in_valid = 1'b0;
    operand = '0;

    // reset state
    start_test();
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge clk);
      // before the first edge out_valid is still unknown
      if (i > 0)
      begin
        check_value("out_valid during reset", out_valid, 0);
      end
    end
    reset <= 1'b0;
    repeat (IDLE_CHECK_CYCLES)
    begin
      @(posedge clk);
      check_value("out_valid idle after reset", out_valid, 0);
    end
    end_test("reset state");

    // corners around the modulus, powers of two, all ones
    start_test();
    send_operand('d0);
    send_operand('d4050);
    send_operand('d4051);
    send_operand('d4052);
    send_operand('d8102);
    for (int i = 0; i < OPERAND_W; i++)
    begin
      op = '0;
      op[i] = 1'b1;
      send_operand(op);
    end
    send_operand('1);
    end_test("corner operands");

    // one digit active at a time, full value and lowest bit
    start_test();
    for (int k = 0; k < NUM_DIGITS; k++)
    begin
      op = '0;
      // top digit only has two bits inside the operand
      for (int b = 0; b < DIGIT_W && k * DIGIT_W + b < OPERAND_W; b++)
      begin
        op[k * DIGIT_W + b] = 1'b1;
      end
      send_operand(op);
      op = '0;
      op[k * DIGIT_W] = 1'b1;
      send_operand(op);
    end
    end_test("single digit");

    // back to back operands, latency checked by the stamps
    start_test();
    for (int i = 0; i < N_BURST; i++)
    begin
      random_operand(op);
      send_operand(op);
    end
    end_test("full throughput");

    // in_valid on about half of the cycles
    start_test();
    n = 0;
    while (n < N_GAPPED)
    begin
      r = $random(seed);
      if (r[0])
      begin
        random_operand(op);
        send_operand(op);
        n++;
      end
      else
      begin
        idle_cycle();
      end
    end
    end_test("gapped stream");

    // reset with operands in flight
    start_test();
    for (int i = 0; i < N_RST_PRE; i++)
    begin
      random_operand(op);
      send_operand(op);
    end
    reset <= 1'b1;
    in_valid <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (IDLE_CHECK_CYCLES)
    begin
      @(posedge clk);
      check_value("out_valid after mid-stream reset", out_valid, 0);
    end
    for (int i = 0; i < N_RST_POST; i++)
    begin
      random_operand(op);
      send_operand(op);
    end
    end_test("reset mid-stream");

    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+dv
verilog/mod_pkg.sv
verilog/digit_residue_rom.sv
verilog/residue_adder_tree.sv
verilog/fold_reduce.sv
verilog/mod_reduce_top.sv
dv/mod_reduce_tb.sv
